// File: common/fetch_settings.svh
////////////////////////////////////////
// fetch stage build settings
//  - prefetch fifo depth
//  - outstanding bus transfer limit
//  - instruction / address width
////////////////////////////////////////

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// words held between bus and if/id register
`define FETCH_FIFO_DEPTH 2

// granted but unanswered transfers on the instruction bus
`define FETCH_MAX_OUTSTANDING 2

`define FETCH_XLEN 32 // address and data width

`endif

// File: common/fetch_pkg.sv
////////////////////////////////////////
// fetch stage shared types
//  - next pc and exception target selects
//  - instruction bus request / response
//  - trap control bundle, if/id word
//  - instruction word union (rv32 / rvc)
////////////////////////////////////////

`include "fetch_settings.svh"

package fetch_pkg;

  ////////////////////////////////////////
  // pc selects
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001, // refetch after id pc
    PC_JUMP      = 3'b010, // target from id
    PC_BRANCH    = 3'b011, // target from ex
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101,
    PC_DRET      = 3'b111
  } pc_mux_e;

  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00, // trap base
    EXC_PC_IRQ       = 2'b01, // vectored
    EXC_PC_DBD       = 2'b10  // debug halt
  } exc_pc_mux_e;

  ////////////////////////////////////////
  // instruction bus
  typedef struct packed {
    logic                   req;
    logic [`FETCH_XLEN-1:0] addr;
  } ibus_req_t;

  typedef struct packed {
    logic                   gnt;
    logic                   rvalid; // one per granted transfer, in order
    logic [`FETCH_XLEN-1:0] rdata;
  } ibus_rsp_t;

  // trap and return addresses from the csr side
  typedef struct packed {
    logic [23:0]            trap_base;
    logic [4:0]             exc_vec;
    logic [29:0]            dm_halt;
    logic [`FETCH_XLEN-1:0] mepc;
    logic [`FETCH_XLEN-1:0] depc;
  } trap_ctl_t;

  typedef struct packed {
    logic                   valid;
    logic [`FETCH_XLEN-1:0] rdata;  // expanded instruction
    logic [`FETCH_XLEN-1:0] pc;
    logic                   is_compressed;
    logic                   illegal_c;
  } if_id_t;

  ////////////////////////////////////////
  // one fetched word, two decodings
  typedef union packed {
    struct packed {
      logic [11:0] imm;    // low 5 bits double as rs2
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } rv32;
    struct packed {
      logic [15:0] upper;  // ignored, one instr per word
      logic [2:0]  funct3;
      logic        imm12;
      logic [4:0]  rd_rs1;
      logic [4:0]  rs2;    // also imm[4:0] on ci forms
      logic [1:0]  op;
    } rvc;
  } instr_word_u;

endpackage

// File: src/pc_select.sv
////////////////////////////////////////
// next fetch address selection
//  - exception / irq / debug target
//  - boot, jump, branch, return, fence.i
////////////////////////////////////////

`timescale 1ns/10ps

module pc_select (
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  fetch_pkg::trap_ctl_t   trap_i,
  input  logic [30:0]            boot_addr_i,
  input  logic [31:0]            jump_target_id_i,
  input  logic [31:0]            jump_target_ex_i,
  input  logic [31:0]            pc_id_i,
  output logic [31:0]            fetch_addr_o
);

  logic [31:0] exc_pc;     // handler address
  logic [31:0] fetch_addr; // before bit 0 clear

  ////////////////////////////////////////
  // exception target
  always_comb begin
    unique case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_EXCEPTION: exc_pc = {trap_i.trap_base, 8'h00}; // common entry
      fetch_pkg::EXC_PC_IRQ:       exc_pc = {trap_i.trap_base, 1'b0, trap_i.exc_vec, 2'b00};
      fetch_pkg::EXC_PC_DBD:       exc_pc = {trap_i.dm_halt, 2'b00};   // debug module rom
      default:                     exc_pc = {trap_i.trap_base, 8'h00};
    endcase
  end

  ////////////////////////////////////////
  // fetch address mux
  always_comb begin
    unique case (pc_mux_i)
      fetch_pkg::PC_BOOT:      fetch_addr = {boot_addr_i, 1'b0};
      fetch_pkg::PC_JUMP:      fetch_addr = jump_target_id_i;
      fetch_pkg::PC_BRANCH:    fetch_addr = jump_target_ex_i;
      fetch_pkg::PC_EXCEPTION: fetch_addr = exc_pc;
      fetch_pkg::PC_MRET:      fetch_addr = trap_i.mepc; // back from trap
      fetch_pkg::PC_DRET:      fetch_addr = trap_i.depc; // back from debug
      fetch_pkg::PC_FENCEI:    fetch_addr = pc_id_i + 32'd4; // reload after fence.i
      default:                 fetch_addr = {boot_addr_i, 1'b0};
    endcase
  end

  // halfword aligned at least
  assign fetch_addr_o = {fetch_addr[31:1], 1'b0};

endmodule

// File: prefetch/prefetch_fifo.sv
////////////////////////////////////////
// fall-through fifo of fetched words
//  - word + fetch address per entry
//  - flush drops all entries
////////////////////////////////////////

`timescale 1ns/10ps
`include "fetch_settings.svh"

module prefetch_fifo (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush_i,
  input  logic                                      push_i,
  input  logic [`FETCH_XLEN-1:0]                    push_data_i,
  input  logic [`FETCH_XLEN-1:0]                    push_addr_i,
  input  logic                                      pop_i,
  output logic                                      valid_o,
  output logic [`FETCH_XLEN-1:0]                    data_o,
  output logic [`FETCH_XLEN-1:0]                    addr_o,
  output logic [$clog2(`FETCH_FIFO_DEPTH + 1)-1:0] count_o
);

  localparam int PTR_W = $clog2(`FETCH_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FETCH_FIFO_DEPTH + 1);

  logic [`FETCH_XLEN-1:0] mem_data [`FETCH_FIFO_DEPTH];
  logic [`FETCH_XLEN-1:0] mem_addr [`FETCH_FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]       count_q;
  logic                   pop_en; // pop only a present head

  assign valid_o = (count_q != '0);
  assign data_o  = mem_data[rd_ptr_q]; // head shows without a clock
  assign addr_o  = mem_addr[rd_ptr_q];
  assign count_o = count_q;
  assign pop_en  = pop_i & valid_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin // flush wins over push / pop
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`FETCH_FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_en)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`FETCH_FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push_i, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // none or both
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_data[wr_ptr_q] <= push_data_i;
      mem_addr[wr_ptr_q] <= push_addr_i;
    end
  end

  // the request throttle upstream must keep a slot free for every transfer
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push_i && !flush_i && !pop_en |-> count_q < CNT_W'(`FETCH_FIFO_DEPTH));

endmodule

// File: prefetch/prefetch_buffer.sv
////////////////////////////////////////
// prefetch buffer
//  - instruction bus request sequencer
//  - outstanding / stale transfer count
//  - in-order grant address queue
//  - prefetch fifo instance
////////////////////////////////////////

`timescale 1ns/10ps
`include "fetch_settings.svh"

module prefetch_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   branch_i,
  input  logic [`FETCH_XLEN-1:0] branch_addr_i,
  input  logic                   fetch_ready_i,
  output logic                   fetch_valid_o,
  output logic [`FETCH_XLEN-1:0] fetch_rdata_o,
  output logic [`FETCH_XLEN-1:0] fetch_addr_o,
  output fetch_pkg::ibus_req_t   ibus_req_o,
  input  fetch_pkg::ibus_rsp_t   ibus_rsp_i,
  output logic                   busy_o
);

  localparam int CNT_W = $clog2(`FETCH_MAX_OUTSTANDING + 1);
  localparam int AQ_W  = $clog2(`FETCH_MAX_OUTSTANDING);
  localparam int FC_W  = $clog2(`FETCH_FIFO_DEPTH + 1);

  logic [`FETCH_XLEN-1:0] addr_q;         // next address to request
  logic                   active_q;       // fetching started
  logic [CNT_W-1:0]       cnt_q, cnt_n;   // granted, not yet answered
  logic [CNT_W-1:0]       stale_q;        // answers still to drop
  logic [`FETCH_XLEN-1:0] aq_mem [`FETCH_MAX_OUTSTANDING];
  logic [AQ_W-1:0]        aq_wr_q, aq_rd_q;
  logic [FC_W-1:0]        fifo_count;
  logic                   room, granted, rsp_fresh;

  ////////////////////////////////////////
  // request side
  // a slot is reserved per transfer so every answer fits in the fifo
  assign room = (cnt_q < `FETCH_MAX_OUTSTANDING) &&
                ((fifo_count + cnt_q) < `FETCH_FIFO_DEPTH);

  assign ibus_req_o.req  = active_q & room;
  assign ibus_req_o.addr = addr_q;
  assign granted         = ibus_req_o.req & ibus_rsp_i.gnt;
  assign rsp_fresh       = ibus_rsp_i.rvalid & (stale_q == '0);
  assign busy_o          = (cnt_q != '0) | ibus_req_o.req;

  always_comb begin
    case ({granted, ibus_rsp_i.rvalid})
      2'b10:   cnt_n = cnt_q + 1'b1;
      2'b01:   cnt_n = cnt_q - 1'b1;
      default: cnt_n = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      addr_q   <= '0;
      cnt_q    <= '0;
      stale_q  <= '0;
      aq_wr_q  <= '0;
      aq_rd_q  <= '0;
    end else begin
      cnt_q <= cnt_n;
      if (branch_i)
        active_q <= 1'b1;
      else if (!req_i && !(ibus_req_o.req && !ibus_rsp_i.gnt))
        active_q <= 1'b0; // stop, but never drop an ungranted request
      if (branch_i)
        addr_q <= branch_addr_i;
      else if (granted)
        addr_q <= addr_q + `FETCH_XLEN'd4; // one instr per word
      if (branch_i)
        stale_q <= cnt_n; // all still in flight belong to the old stream
      else if (ibus_rsp_i.rvalid && stale_q != '0)
        stale_q <= stale_q - 1'b1;
      if (granted)
        aq_wr_q <= (aq_wr_q == AQ_W'(`FETCH_MAX_OUTSTANDING - 1)) ? '0 : aq_wr_q + 1'b1;
      if (ibus_rsp_i.rvalid)
        aq_rd_q <= (aq_rd_q == AQ_W'(`FETCH_MAX_OUTSTANDING - 1)) ? '0 : aq_rd_q + 1'b1;
    end
  end

  // address of each granted transfer, popped with its answer
  always_ff @(posedge clk) begin
    if (granted)
      aq_mem[aq_wr_q] <= addr_q;
  end

  ////////////////////////////////////////
  // response side
  prefetch_fifo i_prefetch_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (branch_i),
    .push_i      (rsp_fresh),
    .push_data_i (ibus_rsp_i.rdata),
    .push_addr_i (aq_mem[aq_rd_q]),
    .pop_i       (fetch_valid_o & fetch_ready_i),
    .valid_o     (fetch_valid_o),
    .data_o      (fetch_rdata_o),
    .addr_o      (fetch_addr_o),
    .count_o     (fifo_count)
  );

  // a redirect may replace a pending request, nothing else may
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ibus_req_o.req && !ibus_rsp_i.gnt && !branch_i |=>
      ibus_req_o.req && $stable(ibus_req_o.addr));

  // memory answers only what was granted
  a_rvalid_tracked: assert property (@(posedge clk) disable iff (!rst_n)
    ibus_rsp_i.rvalid |-> cnt_q != '0);

endmodule

// File: src/compressed_decoder.sv
////////////////////////////////////////
// compressed instruction expander
//  - c.addi c.li c.lw c.sw c.j c.mv c.add
//  - other rvc encodings flagged illegal
////////////////////////////////////////

`timescale 1ns/10ps

module compressed_decoder (
  input  fetch_pkg::instr_word_u instr_i,
  output logic [31:0]            instr_o,
  output logic                   is_compressed_o,
  output logic                   illegal_c_o
);

  logic [15:0] c;     // raw low half for immediate scatter
  logic [4:0]  rs1_p; // rs1' in x8..x15
  logic [4:0]  rd_p;  // rd' / rs2' in x8..x15

  assign c     = instr_i[15:0];
  assign rs1_p = {2'b01, instr_i.rvc.rd_rs1[2:0]};
  assign rd_p  = {2'b01, instr_i.rvc.rs2[2:0]};

  always_comb begin
    instr_o         = instr_i; // full 32 bit word passes as is
    is_compressed_o = 1'b0;
    illegal_c_o     = 1'b0;

    if (instr_i.rv32.opcode[1:0] != 2'b11) begin
      is_compressed_o = 1'b1;
      illegal_c_o     = 1'b1;          // until a supported form matches
      instr_o         = {16'h0000, c}; // unsupported goes on zero-extended

      case ({instr_i.rvc.op, instr_i.rvc.funct3})
        // c.lw -> lw rd', uimm(rs1')
        5'b00_010: begin
          illegal_c_o = 1'b0;
          instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, 3'b010, rd_p, 7'b0000011};
        end
        // c.sw -> sw rs2', uimm(rs1')
        5'b00_110: begin
          illegal_c_o = 1'b0;
          instr_o = {5'b0, c[5], c[12], rd_p, rs1_p, 3'b010,
                     c[11:10], c[6], 2'b00, 7'b0100011};
        end
        // c.addi -> addi rd, rd, simm
        5'b01_000: begin
          illegal_c_o = 1'b0;
          instr_o = {{6{instr_i.rvc.imm12}}, instr_i.rvc.imm12, instr_i.rvc.rs2,
                     instr_i.rvc.rd_rs1, 3'b000, instr_i.rvc.rd_rs1, 7'b0010011};
        end
        // c.li -> addi rd, x0, simm
        5'b01_010: begin
          illegal_c_o = 1'b0;
          instr_o = {{6{instr_i.rvc.imm12}}, instr_i.rvc.imm12, instr_i.rvc.rs2,
                     5'b00000, 3'b000, instr_i.rvc.rd_rs1, 7'b0010011};
        end
        // c.j -> jal x0, offset
        5'b01_101: begin
          illegal_c_o = 1'b0;
          instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                     {9{c[12]}}, 5'b00000, 7'b1101111};
        end
        // c.mv / c.add, rs2 == 0 is jr / jalr / ebreak
        5'b10_100: begin
          if (instr_i.rvc.rs2 != 5'b00000) begin
            illegal_c_o = 1'b0;
            if (instr_i.rvc.imm12) // c.add -> add rd, rd, rs2
              instr_o = {7'b0, instr_i.rvc.rs2, instr_i.rvc.rd_rs1, 3'b000,
                         instr_i.rvc.rd_rs1, 7'b0110011};
            else                   // c.mv  -> add rd, x0, rs2
              instr_o = {7'b0, instr_i.rvc.rs2, 5'b00000, 3'b000,
                         instr_i.rvc.rd_rs1, 7'b0110011};
          end
        end
        default: ; // stays illegal
      endcase
    end
  end

endmodule

// File: src/if_stage.sv
////////////////////////////////////////
// instruction fetch stage top
//  - offset fsm (idle / wait)
//  - if/id pipeline register
//  - pc select, prefetch buffer and
//    compressed expander instances
////////////////////////////////////////

`timescale 1ns/10ps
`include "fetch_settings.svh"

module if_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic [30:0]            boot_addr_i,
  input  fetch_pkg::trap_ctl_t   trap_i,
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [`FETCH_XLEN-1:0] jump_target_id_i,
  input  logic [`FETCH_XLEN-1:0] jump_target_ex_i,
  input  logic                   clear_instr_valid_i,
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  output fetch_pkg::ibus_req_t   ibus_req_o,
  input  fetch_pkg::ibus_rsp_t   ibus_rsp_i,
  output fetch_pkg::if_id_t      if_id_o,
  output logic [`FETCH_XLEN-1:0] pc_if_o,
  output logic                   if_busy_o
);

  typedef enum logic [0:0] {IDLE, WAIT} offset_fsm_e;

  offset_fsm_e            fsm_cs, fsm_ns;
  logic                   valid;      // head word offered to id
  logic                   if_valid;   // if/id register loads
  logic                   branch_req;
  logic [`FETCH_XLEN-1:0] fetch_addr_n;
  logic                   fetch_valid;
  logic [`FETCH_XLEN-1:0] fetch_rdata, fetch_addr;
  logic [`FETCH_XLEN-1:0] instr_exp;  // expander output
  logic                   instr_is_c, instr_ill_c;
  logic                   id_valid_q, id_is_c_q, id_ill_c_q;
  logic [`FETCH_XLEN-1:0] id_rdata_q, id_pc_q;

  pc_select i_pc_select (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .trap_i           (trap_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_id_i (jump_target_id_i),
    .jump_target_ex_i (jump_target_ex_i),
    .pc_id_i          (id_pc_q),        // fence.i restarts after this pc
    .fetch_addr_o     (fetch_addr_n)
  );

  prefetch_buffer i_prefetch_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_req),
    .branch_addr_i (fetch_addr_n),
    .fetch_ready_i (if_valid),       // pop exactly what id takes
    .fetch_valid_o (fetch_valid),
    .fetch_rdata_o (fetch_rdata),
    .fetch_addr_o  (fetch_addr),
    .ibus_req_o    (ibus_req_o),
    .ibus_rsp_i    (ibus_rsp_i),
    .busy_o        (if_busy_o)
  );

  compressed_decoder i_compressed_decoder (
    .instr_i         (fetch_rdata),
    .instr_o         (instr_exp),
    .is_compressed_o (instr_is_c),
    .illegal_c_o     (instr_ill_c)
  );

  ////////////////////////////////////////
  // offset fsm
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) fsm_cs <= IDLE;
    else        fsm_cs <= fsm_ns;
  end

  always_comb begin
    fsm_ns     = fsm_cs;
    branch_req = 1'b0;
    valid      = 1'b0;
    unique case (fsm_cs)
      IDLE: begin
        if (req_i) begin      // first fetch goes to the selected pc
          branch_req = 1'b1;
          fsm_ns     = WAIT;
        end
      end
      WAIT: valid = fetch_valid; // hand the head word on
      default: fsm_ns = IDLE;
    endcase
    if (pc_set_i) begin       // redirect, head belongs to the old stream
      valid      = 1'b0;
      branch_req = 1'b1;
      fsm_ns     = WAIT;
    end
  end

  assign if_valid = valid & id_ready_i & ~halt_if_i;
  assign pc_if_o  = fetch_addr;

  ////////////////////////////////////////
  // if/id register, held while id stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      id_valid_q <= 1'b0;
    else if (if_valid)
      id_valid_q <= 1'b1;
    else if (clear_instr_valid_i)
      id_valid_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (if_valid) begin
      id_rdata_q <= instr_exp;
      id_pc_q    <= fetch_addr;
      id_is_c_q  <= instr_is_c;
      id_ill_c_q <= instr_ill_c;
    end
  end

  assign if_id_o = '{valid:         id_valid_q,
                     rdata:         id_rdata_q,
                     pc:            id_pc_q,
                     is_compressed: id_is_c_q,
                     illegal_c:     id_ill_c_q};

endmodule

// File: verification/imem_model.sv
////////////////////////////////////////
// instruction memory responder
//  - random grant, 1..3 cycle answers
//  - word content from the address
//  - compressed window table
////////////////////////////////////////

`timescale 1ns/10ps

module imem_model (
  input  logic                 clk,
  input  logic                 rst_n,
  input  fetch_pkg::ibus_req_t ibus_req_i,
  output fetch_pkg::ibus_rsp_t ibus_rsp_o
);

  localparam logic [31:0] WIN_BASE  = 32'h0000_0800; // compressed window
  localparam int          WIN_WORDS = 9;

  integer      seed;
  int          cycle;
  logic [15:0] ctab [WIN_WORDS]; // rvc encodings, low half of each word
  logic [31:0] addr_q [$];       // granted, not yet answered
  int          due_q [$];        // cycle each answer may go out
  logic        gnt_q, rvalid_q;
  logic [31:0] rdata_q;

  initial begin
    seed    = 82859;
    ctab[0] = 16'h028D; // c.addi x5, 3
    ctab[1] = 16'h557D; // c.li x10, -1
    ctab[2] = 16'h4044; // c.lw x9, 4(x8)
    ctab[3] = 16'hC588; // c.sw x10, 8(x11)
    ctab[4] = 16'hA801; // c.j +16
    ctab[5] = 16'h8192; // c.mv x3, x4
    ctab[6] = 16'h931E; // c.add x6, x7
    ctab[7] = 16'h8082; // c.jr x1, not expanded
    ctab[8] = 16'h6505; // c.lui x10, 1, not expanded
  end

  // addi x1-ish word that folds in the whole address
  function automatic logic [31:0] word_at(input logic [31:0] a);
    if (a >= WIN_BASE && a < WIN_BASE + 32'(4 * WIN_WORDS))
      return {16'hA5A5, ctab[int'((a - WIN_BASE) >> 2)]}; // upper half is junk
    return {a[13:2] ^ a[25:14], a[30:26], 3'b000, 5'd1 ^ {4'b0000, a[31]}, 7'b0010011};
  endfunction

  assign ibus_rsp_o = '{gnt: gnt_q, rvalid: rvalid_q, rdata: rdata_q};

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
      cycle    <= 0;
      addr_q.delete(); // in-flight work is lost on reset
      due_q.delete();
    end else begin
      cycle    <= cycle + 1;
      gnt_q    <= ($unsigned($random(seed)) % 4) != 0; // grant 3 of 4 cycles
      rvalid_q <= 1'b0;
      if (addr_q.size() != 0 && due_q[0] <= cycle) begin // oldest first
        rvalid_q <= 1'b1;
        rdata_q  <= word_at(addr_q[0]);
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end
      if (ibus_req_i.req && gnt_q) begin
        addr_q.push_back(ibus_req_i.addr);
        due_q.push_back(cycle + 1 + int'($unsigned($random(seed)) % 3));
      end
    end
  end

endmodule

// File: verification/tb_if_stage.sv
////////////////////////////////////////
// fetch stage testbench
//  - clock, reset, stimulus per test
//  - concurrent checks on if/id and bus
//  - per test report and timeout
////////////////////////////////////////

`timescale 1ns/10ps

module tb_if_stage;

  localparam logic [31:0] WIN_BASE   = 32'h0000_0800;
  localparam int          WIN_WORDS  = 9;
  localparam int          MAX_CYCLES = 4000; // cycle limit for the whole run

  logic                   clk = 1'b0;
  logic                   rst_n, req_i, pc_set_i, clear_instr_valid_i;
  logic                   id_ready_i = 1'b1;
  logic                   halt_if_i  = 1'b0;
  logic [30:0]            boot_addr_i;
  logic [31:0]            jump_target_id_i, jump_target_ex_i, pc_if;
  fetch_pkg::trap_ctl_t   trap_i;
  fetch_pkg::pc_mux_e     pc_mux_i;
  fetch_pkg::exc_pc_mux_e exc_pc_mux_i;
  fetch_pkg::ibus_req_t   ibus_req;
  fetch_pkg::ibus_rsp_t   ibus_rsp;
  fetch_pkg::if_id_t      if_id;
  logic                   if_busy;

  integer      seed = 82859;
  int          errors, ntests, err_mark, cycles;
  int          out_cnt;        // transfers granted, not answered
  logic        rand_halt = 1'b0;
  logic        shown_valid;    // if/id state one cycle ago
  logic [31:0] shown_pc, exp_pc;
  logic [31:0] head_pc;        // pc_if_o one cycle ago
  logic        new_instr;
  logic [31:0] exp_tab [WIN_WORDS];

  if_stage i_if_stage (
    .clk(clk), .rst_n(rst_n), .req_i(req_i), .boot_addr_i(boot_addr_i), .trap_i(trap_i),
    .pc_set_i(pc_set_i), .pc_mux_i(pc_mux_i), .exc_pc_mux_i(exc_pc_mux_i),
    .jump_target_id_i(jump_target_id_i), .jump_target_ex_i(jump_target_ex_i),
    .clear_instr_valid_i(clear_instr_valid_i), .halt_if_i(halt_if_i),
    .id_ready_i(id_ready_i), .ibus_req_o(ibus_req), .ibus_rsp_i(ibus_rsp),
    .if_id_o(if_id), .pc_if_o(pc_if), .if_busy_o(if_busy)
  );

  imem_model i_imem_model (
    .clk(clk), .rst_n(rst_n), .ibus_req_i(ibus_req), .ibus_rsp_o(ibus_rsp)
  );

  initial forever #50 clk = ~clk; // 100 ns

  ////////////////////////////////////////
  // expected values
  function automatic logic in_window(input logic [31:0] a);
    return a >= WIN_BASE && a < WIN_BASE + 32'(4 * WIN_WORDS);
  endfunction

  function automatic logic [31:0] exp_rdata(input logic [31:0] a);
    if (in_window(a))
      return exp_tab[int'((a - WIN_BASE) >> 2)];
    return {a[13:2] ^ a[25:14], a[30:26], 3'b000, 5'd1 ^ {4'b0000, a[31]}, 7'b0010011};
  endfunction

  function automatic logic exp_illegal(input logic [31:0] a);
    return in_window(a) && (a - WIN_BASE) >= 32'd28; // last two window words
  endfunction

  // where a redirect must land
  function automatic logic [31:0] redirect_target();
    logic [31:0] t;
    case (pc_mux_i)
      fetch_pkg::PC_JUMP:   t = jump_target_id_i;
      fetch_pkg::PC_BRANCH: t = jump_target_ex_i;
      fetch_pkg::PC_MRET:   t = trap_i.mepc;
      fetch_pkg::PC_DRET:   t = trap_i.depc;
      fetch_pkg::PC_FENCEI: t = if_id.pc + 32'd4;
      fetch_pkg::PC_EXCEPTION: begin
        if (exc_pc_mux_i == fetch_pkg::EXC_PC_IRQ)
          t = 32'(trap_i.trap_base) * 256 + 32'(trap_i.exc_vec) * 4;
        else if (exc_pc_mux_i == fetch_pkg::EXC_PC_DBD)
          t = 32'(trap_i.dm_halt) * 4;
        else
          t = 32'(trap_i.trap_base) * 256;
      end
      default: t = 32'(boot_addr_i) * 2;
    endcase
    return t & ~32'd1;
  endfunction

  initial begin
    exp_tab[0] = 32'h0032_8293; // addi x5, x5, 3
    exp_tab[1] = 32'hFFF0_0513; // addi x10, x0, -1
    exp_tab[2] = 32'h0044_2483; // lw x9, 4(x8)
    exp_tab[3] = 32'h00A5_A423; // sw x10, 8(x11)
    exp_tab[4] = 32'h0100_006F; // jal x0, 16
    exp_tab[5] = 32'h0040_01B3; // add x3, x0, x4
    exp_tab[6] = 32'h0073_0333; // add x6, x6, x7
    exp_tab[7] = 32'h0000_8082; // passed on zero-extended
    exp_tab[8] = 32'h0000_6505;
  end

  ////////////////////////////////////////
  // reference tracking
  assign new_instr = if_id.valid && (!shown_valid || if_id.pc != shown_pc);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shown_valid <= 1'b0;
      shown_pc    <= '0;
      head_pc     <= '0;
      exp_pc      <= 32'(boot_addr_i) * 2;
      out_cnt     <= 0;
    end else begin
      shown_valid <= if_id.valid;
      shown_pc    <= if_id.pc;
      head_pc     <= pc_if;
      out_cnt     <= out_cnt + int'(ibus_req.req && ibus_rsp.gnt) - int'(ibus_rsp.rvalid);
      if (pc_set_i) exp_pc <= redirect_target(); // old stream is dead
      else if (new_instr) exp_pc <= if_id.pc + 32'd4;
    end
  end

  // random decode stalls, halt pulses only when asked for
  always @(posedge clk) begin
    id_ready_i <= ($unsigned($random(seed)) % 4) != 0;
    halt_if_i  <= rand_halt && ($unsigned($random(seed)) % 6) == 0;
  end

  task automatic report_mismatch(input string name, input logic [31:0] got, exp);
    errors++;
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("at %0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////
  // checks
  a_pc_order: assert property (@(posedge clk) disable iff (!rst_n)
    new_instr |-> if_id.pc == exp_pc)
    else report_mismatch("if_id_o.pc", $sampled(if_id.pc), $sampled(exp_pc));
  a_pc_if: assert property (@(posedge clk) disable iff (!rst_n)
    new_instr |-> head_pc == exp_pc)
    else report_mismatch("pc_if_o", $sampled(head_pc), $sampled(exp_pc));
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    new_instr |-> if_id.rdata == exp_rdata(if_id.pc))
    else report_mismatch("if_id_o.rdata", $sampled(if_id.rdata), exp_rdata($sampled(if_id.pc)));
  a_is_c: assert property (@(posedge clk) disable iff (!rst_n)
    new_instr |-> if_id.is_compressed == in_window(if_id.pc))
    else report_mismatch("if_id_o.is_compressed", 32'($sampled(if_id.is_compressed)),
                         32'(in_window($sampled(if_id.pc))));
  a_ill_c: assert property (@(posedge clk) disable iff (!rst_n)
    new_instr |-> if_id.illegal_c == exp_illegal(if_id.pc))
    else report_mismatch("if_id_o.illegal_c", 32'($sampled(if_id.illegal_c)),
                         32'(exp_illegal($sampled(if_id.pc))));
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    if_id.valid && (!id_ready_i || halt_if_i) |=> $stable(if_id.pc) && $stable(if_id.rdata))
    else report_failure("if_id_o changed while decode did not take it");
  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    if_busy == (ibus_req.req || out_cnt != 0))
    else report_mismatch("if_busy_o", 32'($sampled(if_busy)),
                         32'($sampled(ibus_req.req) || $sampled(out_cnt) != 0));
  a_bus_addr: assert property (@(posedge clk) disable iff (!rst_n)
    ibus_req.req && !ibus_rsp.gnt && !pc_set_i |=> ibus_req.req && $stable(ibus_req.addr))
    else report_failure("request dropped or address moved before grant");
  a_bus_limit: assert property (@(posedge clk) disable iff (!rst_n) out_cnt <= 2)
    else report_failure("more than two bus transfers outstanding");
  a_reset_req: assert property (@(posedge clk) !rst_n |-> !ibus_req.req)
    else report_failure("instruction request high during reset");

  ////////////////////////////////////////
  // stimulus
  task automatic wait_instrs(input int n);
    int k;
    k = 0;
    while (k < n) begin
      @(posedge clk);
      if (new_instr) k++;
    end
  endtask

  task automatic redirect(input fetch_pkg::pc_mux_e m, input fetch_pkg::exc_pc_mux_e x);
    @(posedge clk);
    pc_mux_i            <= m;
    exc_pc_mux_i        <= x;
    pc_set_i            <= 1'b1;
    clear_instr_valid_i <= 1'b1; // decode flushes too
    @(posedge clk);
    pc_set_i            <= 1'b0;
    clear_instr_valid_i <= 1'b0;
    wait_instrs(5);
  endtask

  task automatic end_test(input string name);
    ntests++;
    $display("test %-12s %s", name, (errors == err_mark) ? "ok" : "failed");
    err_mark = errors;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    fetch_pkg::pc_mux_e modes [5];
    modes = '{fetch_pkg::PC_JUMP, fetch_pkg::PC_BRANCH, fetch_pkg::PC_MRET,
              fetch_pkg::PC_DRET, fetch_pkg::PC_FENCEI};
    errors              = 0;
    ntests              = 0;
    err_mark            = 0;
    cycles              = 0;
    rst_n              <= 1'b0;
    req_i               = 1'b0;
    boot_addr_i         = 31'h0000_0080; // fetch starts at 0x100
    trap_i              = '{trap_base: 24'h12, exc_vec: 5'd5, dm_halt: 30'h400,
                            mepc: 32'h3000, depc: 32'h4000};
    pc_set_i            = 1'b0;
    pc_mux_i            = fetch_pkg::PC_BOOT;
    exc_pc_mux_i        = fetch_pkg::EXC_PC_EXCEPTION;
    jump_target_id_i    = 32'h1000;
    jump_target_ex_i    = 32'h2000;
    clear_instr_valid_i = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    req_i <= 1'b1;
    wait_instrs(12);
    end_test("boot");
    foreach (modes[i]) redirect(modes[i], fetch_pkg::EXC_PC_EXCEPTION);
    end_test("redirect");
    redirect(fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_EXCEPTION);
    redirect(fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_IRQ);
    redirect(fetch_pkg::PC_EXCEPTION, fetch_pkg::EXC_PC_DBD);
    end_test("exception");
    jump_target_id_i <= WIN_BASE;
    redirect(fetch_pkg::PC_JUMP, fetch_pkg::EXC_PC_EXCEPTION);
    wait_instrs(8); // rest of the window and past it
    end_test("compressed");
    rand_halt <= 1'b1;
    wait_instrs(40);
    rand_halt <= 1'b0;
    end_test("backpressure");
    @(posedge clk);
    rst_n    <= 1'b0; // reset in the middle of a stream
    pc_mux_i <= fetch_pkg::PC_BOOT;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    wait_instrs(6);
    end_test("bus_reset");
    $display("%0d tests run, %0d checks failed", ntests, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: src.f
+incdir+common
common/fetch_pkg.sv
src/pc_select.sv
prefetch/prefetch_fifo.sv
prefetch/prefetch_buffer.sv
src/compressed_decoder.sv
src/if_stage.sv
verification/imem_model.sv
verification/tb_if_stage.sv
